// ==== sources.f ====
src/mulDivPkg.sv
src/hiLoWriteIf.sv
src/seqDivider.sv
src/hiLoRegs.sv
src/mulDivUnit.sv
src/mulDivTop.sv
tests/clkGen.sv
tests/mulDivAsserts.sv
tests/mulDivTb.sv

// ==== Makefile ====
# Verilator build and run for the mul/div block; override any variable on the command line

VERILATOR ?= verilator
TOP       ?= mulDivTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass or fail is taken from the log, not from the exit code
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tests/mulDivTb.sv ====
// directed tests; stimulus changes on the rising edge, outputs are sampled on the falling edge
`timescale 1ns/1ps

module mulDivTb;
    import mulDivPkg::*;

    // longest single wait in cycles
    localparam int WaitLimit = 100;

    logic  clk;
    logic  rst;
    logic  opValid;
    mdOp_t op;
    word_t srcA;
    word_t srcB;
    logic  busy;
    word_t hiRd;
    word_t loRd;

    int     mismatchCount;
    int     failureCount;
    integer seed;

    clkGen clock (
        .clk (clk),
        .rst (rst)
    );

    mulDivTop uut (
        .clk     (clk),
        .rst     (rst),
        .opValid (opValid),
        .op      (op),
        .srcA    (srcA),
        .srcB    (srcB),
        .busy    (busy),
        .hiRd    (hiRd),
        .loRd    (loRd)
    );

    // ************************************************************************
    // checking and golden model
    // ************************************************************************

    task automatic checkValue(input string testName, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            mismatchCount++;
            $display("error: %s expected %h actual %h", testName, expected, actual);
        end
    endtask

    // {HI, LO} from 64-bit arithmetic
    // signed divide truncates toward zero, remainder keeps the dividend's sign
    function automatic logic [63:0] modelResult(input mdOp_t code, input word_t a, input word_t b);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        logic [63:0]     res;
        sa  = longint'($signed(a));
        sb  = longint'($signed(b));
        ua  = 64'(a);
        ub  = 64'(b);
        res = '0;
        case (code)
            OpMult:  res = sa * sb;
            OpMultu: res = ua * ub;
            OpDiv: begin
                // zero divisor gives all-ones magnitude, negated for a negative dividend
                if (b == '0) begin
                    res = {a, (a[31] ? 32'h0000_0001 : 32'hffff_ffff)};
                end else begin
                    res = {32'(sa % sb), 32'(sa / sb)};
                end
            end
            OpDivu: begin
                if (b == '0) begin
                    res = {a, 32'hffff_ffff};
                end else begin
                    res = {32'(ua % ub), 32'(ua / ub)};
                end
            end
            default: res = '0;
        endcase
        return res;
    endfunction

    // ************************************************************************
    // drive and wait
    // ************************************************************************

    // op offered for one edge and taken only if busy is low there
    task automatic issueOp(input mdOp_t code, input word_t a, input word_t b);
        @(posedge clk);
        opValid <= 1'b1;
        op      <= code;
        srcA    <= a;
        srcB    <= b;
        @(posedge clk);
        opValid <= 1'b0;
    endtask

    task automatic waitIdle(input string testName);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy && cycles < WaitLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            failureCount++;
            $display("%s: busy did not fall within %0d cycles", testName, WaitLimit);
        end
    endtask

    task automatic runAndCheck(input string testName, input mdOp_t code,
                               input word_t a, input word_t b);
        logic [63:0] expected;
        expected = modelResult(code, a, b);
        issueOp(code, a, b);
        waitIdle(testName);
        checkValue({testName, " hi"}, expected[63:32], hiRd);
        checkValue({testName, " lo"}, expected[31:0], loRd);
    endtask

    // ************************************************************************
    // tests
    // ************************************************************************

    task automatic testReset();
        int cycles;
        cycles = 0;
        while (rst !== 1'b1 && cycles < WaitLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (rst !== 1'b1) begin
            failureCount++;
            $display("reset: rst was never released");
        end
        @(negedge clk);
        checkValue("reset hi", '0, hiRd);
        checkValue("reset lo", '0, loRd);
        checkValue("reset busy", '0, {31'b0, busy});
    endtask

    task automatic testMoves();
        word_t hiVal;
        word_t loVal;
        hiVal = $random(seed);
        loVal = $random(seed);
        // MTHI forwarded in the issuing cycle
        @(posedge clk);
        opValid <= 1'b1;
        op      <= OpMthi;
        srcA    <= hiVal;
        srcB    <= '0;
        @(negedge clk);
        checkValue("mthi same cycle", hiVal, hiRd);
        @(posedge clk);
        opValid <= 1'b0;
        @(negedge clk);
        checkValue("mthi held", hiVal, hiRd);
        // LO still at its reset value
        checkValue("mthi lo kept", '0, loRd);
        // MTLO must leave HI alone
        @(posedge clk);
        opValid <= 1'b1;
        op      <= OpMtlo;
        srcA    <= loVal;
        @(negedge clk);
        checkValue("mtlo same cycle", loVal, loRd);
        @(posedge clk);
        opValid <= 1'b0;
        @(negedge clk);
        checkValue("mtlo held", loVal, loRd);
        checkValue("mtlo hi kept", hiVal, hiRd);
    endtask

    task automatic testMultiply();
        word_t a;
        word_t b;
        int    i;
        runAndCheck("mult min by -1", OpMult, 32'h8000_0000, 32'hffff_ffff);
        runAndCheck("multu min by max", OpMultu, 32'h8000_0000, 32'hffff_ffff);
        runAndCheck("mult neg by neg", OpMult, 32'hffff_fffd, 32'hffff_fff9);
        runAndCheck("multu max by max", OpMultu, 32'hffff_ffff, 32'hffff_ffff);
        for (i = 0; i < 6; i++) begin
            a = $random(seed);
            b = $random(seed);
            runAndCheck("mult random", OpMult, a, b);
            runAndCheck("multu random", OpMultu, a, b);
        end
    endtask

    task automatic testDivide();
        word_t a;
        word_t b;
        int    i;
        runAndCheck("div neg by pos", OpDiv, -100, 7);
        runAndCheck("div pos by neg", OpDiv, 100, -7);
        runAndCheck("div neg by neg", OpDiv, -100, -7);
        runAndCheck("div min by -1", OpDiv, 32'h8000_0000, 32'hffff_ffff);
        runAndCheck("divu large", OpDivu, 32'hffff_ff9c, 32'd7);
        runAndCheck("div by zero pos", OpDiv, 32'd1234, 32'd0);
        runAndCheck("div by zero neg", OpDiv, -300, 32'd0);
        runAndCheck("divu by zero", OpDivu, 32'hdead_beef, 32'd0);
        for (i = 0; i < 4; i++) begin
            a = $random(seed);
            b = $random(seed);
            runAndCheck("div random", OpDiv, a, b);
            // small divisor for a wide quotient
            runAndCheck("divu random", OpDivu, a, b >> 20);
        end
    endtask

    task automatic testBackPressure();
        word_t       a;
        logic [63:0] expected;
        a        = $random(seed);
        expected = modelResult(OpDiv, a, 32'd13);
        // known HI and LO so that a wrongly taken op shows up
        issueOp(OpMthi, 32'h0bad_f00d, '0);
        issueOp(OpMtlo, 32'h5eed_cafe, '0);
        issueOp(OpDiv, a, 32'd13);
        // both land while the divide still holds busy
        issueOp(OpMthi, 32'hdead_beef, '0);
        issueOp(OpMult, 32'h1234_5678, 32'h9abc_def0);
        // a taken mult would be finishing in this cycle
        @(negedge clk);
        if (!busy) begin
            failureCount++;
            $display("back-pressure: divide was no longer busy while dropped ops were offered");
        end
        checkValue("back-pressure hi held", 32'h0bad_f00d, hiRd);
        checkValue("back-pressure lo held", 32'h5eed_cafe, loRd);
        waitIdle("back-pressure");
        checkValue("back-pressure hi", expected[63:32], hiRd);
        checkValue("back-pressure lo", expected[31:0], loRd);
    endtask

    // ************************************************************************
    // run
    // ************************************************************************

    initial begin
        seed          = 32'h8d47_6fce;
        mismatchCount = 0;
        failureCount  = 0;
        opValid       = 1'b0;
        op            = OpMult;
        srcA          = '0;
        srcB          = '0;
        testReset();
        testMoves();
        testMultiply();
        testDivide();
        testBackPressure();
        failureCount += uut.mdUnit.unitChecks.assertFailures;
        $display("errors: %0d value mismatches, %0d other failures", mismatchCount, failureCount);
        if (mismatchCount == 0 && failureCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/mulDivAsserts.sv ====
// bound into mulDivUnit; checks are off while rst is low, failures are also counted for the tb
`timescale 1ns/1ps

module mulDivAsserts (
    input logic clk,
    input logic rst,
    input logic finish,
    input logic hiWr,
    input logic loWr,
    input logic busy
);

    // read back by the testbench at the end of the run
    int assertFailures = 0;

    // result write and move never share a cycle
    finishAlone: assert property (@(posedge clk) disable iff (!rst) finish |-> !(hiWr || loWr))
        else begin
            assertFailures++;
            $error("finish raised together with a move strobe");
        end

    // result pulse is a single cycle
    finishPulse: assert property (@(posedge clk) disable iff (!rst) finish |=> !finish)
        else begin
            assertFailures++;
            $error("finish stayed high for more than one cycle");
        end

    // unit is free again right after the result lands
    busyClears: assert property (@(posedge clk) disable iff (!rst) finish |=> !busy)
        else begin
            assertFailures++;
            $error("busy still high in the cycle after finish");
        end

endmodule

bind mulDivUnit mulDivAsserts unitChecks (
    .clk    (clk),
    .rst    (rst),
    .finish (wr.finish),
    .hiWr   (wr.hiWr),
    .loWr   (wr.loWr),
    .busy   (busy)
);

// ==== tests/clkGen.sv ====
// free-running 4 ns clock; rst is held low for the first 8 rising edges, then released
`timescale 1ns/1ps

module clkGen (
    output logic clk,
    output logic rst
);

    // 2 ns high, 2 ns low
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // active low reset, released on the edge like any other stimulus
    initial begin
        rst = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

// ==== src/mulDivTop.sv ====
// caller must hold off while busy is high; dropped ops are not reported
`timescale 1ns/1ps

module mulDivTop (
    input  logic              clk,
    input  logic              rst,
    input  logic              opValid,
    input  mulDivPkg::mdOp_t  op,
    input  mulDivPkg::word_t  srcA,
    input  mulDivPkg::word_t  srcB,
    output logic              busy,
    output mulDivPkg::word_t  hiRd,
    output mulDivPkg::word_t  loRd
);

    // ************************************************************************
    // HI/LO write path between unit and registers
    // ************************************************************************

    hiLoWriteIf wrBus ();

    // issue, multiply, divide
    mulDivUnit mdUnit (
        .clk     (clk),
        .rst     (rst),
        .opValid (opValid),
        .op      (op),
        .srcA    (srcA),
        .srcB    (srcB),
        .busy    (busy),
        .wr      (wrBus.source)
    );

    // special registers with forwarding read ports
    hiLoRegs hiLo (
        .clk  (clk),
        .rst  (rst),
        .wr   (wrBus.sink),
        .hiRd (hiRd),
        .loRd (loRd)
    );

endmodule

// ==== src/mulDivUnit.sv ====
// ops arriving while busy are dropped, not queued; a divide cannot be cancelled once accepted
`timescale 1ns/1ps

module mulDivUnit (
    input  logic              clk,
    input  logic              rst,
    input  logic              opValid,
    input  mulDivPkg::mdOp_t  op,
    input  mulDivPkg::word_t  srcA,
    input  mulDivPkg::word_t  srcB,
    output logic              busy,
    hiLoWriteIf.source        wr
);
    import mulDivPkg::*;

    // two's complement negate
    function automatic word_t negWord(input word_t value);
        return ~value + 1'b1;
    endfunction

    // issue qualifiers
    logic accept;
    logic mulAccept;
    logic divAccept;
    logic finish;

    // multiply
    logic signed [2*WordWidth-1:0] prodSigned;
    logic        [2*WordWidth-1:0] prodUnsigned;
    logic        [2*WordWidth-1:0] result;

    // divide
    logic  isSigned;
    word_t magA;
    word_t magB;
    logic  divStart;
    word_t divA;
    word_t divB;
    logic  negQuo;
    logic  negRem;
    logic  divDone;
    word_t quoRaw;
    word_t remRaw;
    word_t quoFixed;
    word_t remFixed;

    // ************************************************************************
    // issue
    // ************************************************************************

    assign accept    = opValid && !busy;
    assign mulAccept = accept && (op == OpMult || op == OpMultu);
    assign divAccept = accept && (op == OpDiv || op == OpDivu);

    // busy from the cycle after acceptance through the finish cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy     <= 1'b0;
            finish   <= 1'b0;
            divStart <= 1'b0;
        end else begin
            if (finish) begin
                busy <= 1'b0;
            end else if (mulAccept || divAccept) begin
                busy <= 1'b1;
            end
            // multiply finishes next cycle, divide one cycle after done
            finish   <= mulAccept || divDone;
            divStart <= divAccept;
        end
    end

    // ************************************************************************
    // multiply
    // ************************************************************************

    // 64-bit context extends signed operands with their sign
    assign prodSigned   = $signed(srcA) * $signed(srcB);
    assign prodUnsigned = srcA * srcB;

    // ************************************************************************
    // divide
    // ************************************************************************

    assign isSigned = (op == OpDiv);
    assign magA = (isSigned && srcA[WordWidth-1]) ? negWord(srcA) : srcA;
    assign magB = (isSigned && srcB[WordWidth-1]) ? negWord(srcB) : srcB;

    // operand magnitudes and result signs, latched at acceptance
    always_ff @(posedge clk) begin
        if (divAccept) begin
            divA   <= magA;
            divB   <= magB;
            // quotient negative when signs differ
            negQuo <= isSigned && (srcA[WordWidth-1] ^ srcB[WordWidth-1]);
            // remainder follows the dividend
            negRem <= isSigned && srcA[WordWidth-1];
        end
    end

    seqDivider divCore (
        .clk       (clk),
        .rst       (rst),
        .start     (divStart),
        .dividend  (divA),
        .divisor   (divB),
        .done      (divDone),
        .quotient  (quoRaw),
        .remainder (remRaw)
    );

    // sign fixup, truncation toward zero
    assign quoFixed = negQuo ? negWord(quoRaw) : quoRaw;
    assign remFixed = negRem ? negWord(remRaw) : remRaw;

    // ************************************************************************
    // result register and write requests
    // ************************************************************************

    // HI takes the upper half / remainder, LO the lower half / quotient
    always_ff @(posedge clk) begin
        if (mulAccept) begin
            result <= (op == OpMult) ? prodSigned : prodUnsigned;
        end else if (divDone) begin
            result <= {remFixed, quoFixed};
        end
    end

    assign wr.finish = finish;
    assign wr.mdHi   = result[2*WordWidth-1:WordWidth];
    assign wr.mdLo   = result[WordWidth-1:0];

    // moves go straight through in the issuing cycle
    // never with finish, since busy covers the finish cycle
    assign wr.hiWr   = accept && (op == OpMthi);
    assign wr.loWr   = accept && (op == OpMtlo);
    assign wr.wrData = srcA;

endmodule

// ==== src/hiLoRegs.sv ====
// read ports forward this cycle's write combinationally, so hiRd/loRd sit on a comb path from the unit
`timescale 1ns/1ps

module hiLoRegs (
    input  logic              clk,
    input  logic              rst,
    hiLoWriteIf.sink          wr,
    output mulDivPkg::word_t  hiRd,
    output mulDivPkg::word_t  loRd
);
    import mulDivPkg::*;

    // architectural registers
    word_t hiReg;
    word_t loReg;

    // value headed into each register this cycle
    word_t hiNext;
    word_t loNext;

    // ************************************************************************
    // write priority: result, then move, then hold
    // ************************************************************************

    always_comb begin
        if (wr.finish) begin
            hiNext = wr.mdHi;
        end else if (wr.hiWr) begin
            hiNext = wr.wrData;
        end else begin
            hiNext = hiReg;
        end
    end

    always_comb begin
        if (wr.finish) begin
            loNext = wr.mdLo;
        end else if (wr.loWr) begin
            loNext = wr.wrData;
        end else begin
            loNext = loReg;
        end
    end

    // both zero out of reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hiReg <= '0;
            loReg <= '0;
        end else begin
            hiReg <= hiNext;
            loReg <= loNext;
        end
    end

    // forwarding read ports
    // a write in flight shows up before the edge, like a bypassed pipeline read
    assign hiRd = hiNext;
    assign loRd = loNext;

endmodule

// ==== src/seqDivider.sv ====
// unsigned only; start is taken when not running, results hold until the next start
`timescale 1ns/1ps

module seqDivider (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  mulDivPkg::word_t  dividend,
    input  mulDivPkg::word_t  divisor,
    output logic              done,
    output mulDivPkg::word_t  quotient,
    output mulDivPkg::word_t  remainder
);
    import mulDivPkg::*;

    localparam int CntWidth = $clog2(DivSteps);

    divState_t state;
    logic [CntWidth-1:0] stepCnt;

    // divisor kept for the whole run
    word_t divReg;
    // quotient shifts in on the right while dividend bits leave on the left
    word_t quoReg;
    word_t remReg;

    // one trial step
    logic [WordWidth:0]   shifted;
    logic [WordWidth+1:0] trial;
    logic                 load;

    // a start during a run is not taken
    assign load = start && (state != DivRun);

    // partial remainder with next dividend bit appended
    assign shifted = {remReg, quoReg[WordWidth-1]};
    // extra top bit so the borrow is never confused with a large remainder
    assign trial = {1'b0, shifted} - {2'b00, divReg};

    // ************************************************************************
    // control FSM
    // ************************************************************************

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= DivIdle;
            stepCnt <= '0;
        end else begin
            case (state)
                DivIdle: begin
                    if (load) begin
                        state   <= DivRun;
                        stepCnt <= '0;
                    end
                end
                DivRun: begin
                    stepCnt <= stepCnt + 1'b1;
                    // last quotient bit done this edge
                    if (stepCnt == CntWidth'(DivSteps - 1)) begin
                        state <= DivDone;
                    end
                end
                default: begin
                    // done lasts this one cycle
                    state   <= load ? DivRun : DivIdle;
                    stepCnt <= '0;
                end
            endcase
        end
    end

    // ************************************************************************
    // datapath
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (load) begin
            divReg <= divisor;
            quoReg <= dividend;
            remReg <= '0;
        end else if (state == DivRun) begin
            // no borrow: keep the difference, quotient bit 1
            // zero divisor never borrows, so all ones
            if (!trial[WordWidth+1]) begin
                remReg <= trial[WordWidth-1:0];
                quoReg <= {quoReg[WordWidth-2:0], 1'b1};
            end else begin
                remReg <= shifted[WordWidth-1:0];
                quoReg <= {quoReg[WordWidth-2:0], 1'b0};
            end
        end
    end

    assign done      = (state == DivDone);
    assign quotient  = quoReg;
    assign remainder = remReg;

endmodule

// ==== src/hiLoWriteIf.sv ====
// finish must not coincide with hiWr or loWr; finish wins in the sink if it ever does
`timescale 1ns/1ps

interface hiLoWriteIf;
    import mulDivPkg::*;

    // multiply or divide result, one-cycle pulse
    logic  finish;
    // result words, valid with finish
    word_t mdHi;
    word_t mdLo;

    // MTHI / MTLO strobes
    logic  hiWr;
    logic  loWr;
    // move data, srcA of the issuing op
    word_t wrData;

    // driven by the mul/div unit
    modport source (
        output finish, mdHi, mdLo,
        output hiWr, loWr, wrData
    );

    // read by the HI/LO registers
    modport sink (
        input finish, mdHi, mdLo,
        input hiWr, loWr, wrData
    );

endinterface

// ==== src/mulDivPkg.sv ====
// fixed to the 32-bit MIPS word; the op and state encodings are shared by the whole design

package mulDivPkg;

    // ************************************************************************
    // word size
    // ************************************************************************

    // data word width of the execute stage
    localparam int WordWidth = 32;

    // operands, HI, LO and write data
    typedef logic [WordWidth-1:0] word_t;

    // ************************************************************************
    // operation codes
    // ************************************************************************

    // six ops accepted by the unit
    // MFHI/MFLO not needed, read ports always visible
    typedef enum logic [2:0] {
        OpMult  = 3'd0,
        OpMultu = 3'd1,
        OpDiv   = 3'd2,
        OpDivu  = 3'd3,
        OpMthi  = 3'd4,
        OpMtlo  = 3'd5
    } mdOp_t;

    // ************************************************************************
    // divider
    // ************************************************************************

    // restoring divider FSM
    typedef enum logic [1:0] {
        DivIdle = 2'd0,
        DivRun  = 2'd1,
        DivDone = 2'd2
    } divState_t;

    // one quotient bit per iteration
    localparam int DivSteps = 32;

endpackage
